// File: src/csc_reg_pkg.sv
// convolution sequencer register types
package csc_reg_pkg;

  typedef logic [31:0] reg_data_t;   // register data word
  typedef logic [11:0] reg_offset_t; // byte offset in 4 KB space
  typedef logic [21:0] csb_addr_t;   // word address on the bus

  // bus request with msb first
  typedef struct packed {
    logic [1:0] level;
    logic [3:0] wrbe;
    logic       srcpriv;
    logic       nposted;    // write wants an ack
    logic       write;
    reg_data_t  wdat;
    csb_addr_t  addr;
  } csb_req_t;

  typedef struct packed {
    logic      is_write;    // 0 read data, 1 write ack
    logic      error;
    reg_data_t rdat;
  } csb_resp_t;

  // one register access after address decode
  typedef struct packed {
    logic        wr_en;
    logic        rd_en;
    reg_offset_t offset;
    reg_data_t   wr_data;
  } reg_access_t;

  // layer config seen by the datapath
  typedef struct packed {
    logic [12:0] datain_width_ext;
    logic [12:0] datain_height_ext;
    logic [12:0] datain_channel_ext;
    logic        conv_mode;
    logic [1:0]  in_precision;
    logic [4:0]  batches;
    logic [15:0] pad_value;
  } conv_cfg_t;

  typedef enum logic [1:0] {
    GROUP_IDLE    = 2'd0,
    GROUP_RUNNING = 2'd1, // consumer points here
    GROUP_PENDING = 2'd2  // armed, waiting for its turn
  } group_status_e;

  ////////////////////////////////////////////////////////////////////////////
  // single group
  localparam reg_offset_t REG_STATUS        = 12'h000; // status_0 [1:0], status_1 [17:16]
  localparam reg_offset_t REG_POINTER       = 12'h004; // producer [0] rw, consumer [16] ro
  localparam reg_offset_t DUAL_BASE         = 12'h008; // first offset of the dual groups

  ////////////////////////////////////////////////////////////////////////////
  // dual group
  localparam reg_offset_t REG_OP_ENABLE     = 12'h008; // op_en [0]
  localparam reg_offset_t REG_MISC_CFG      = 12'h00C; // conv_mode [0], in_precision [9:8],
                                                       // batches [20:16]
  localparam reg_offset_t REG_DATAIN_SIZE_0 = 12'h010; // width [12:0], height [28:16]
  localparam reg_offset_t REG_DATAIN_SIZE_1 = 12'h014; // channel [12:0]
  localparam reg_offset_t REG_PAD_VALUE     = 12'h018; // pad value [15:0]

endpackage

// File: src/csc_csb_bridge.sv
// config bus request bridge
`timescale 1ns/1ps

module csc_csb_bridge (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     csb_req_pvld,
  input  csc_reg_pkg::csb_req_t    csb_req_pd,
  input  csc_reg_pkg::reg_data_t   rd_data,
  output logic                     csb_req_prdy,
  output csc_reg_pkg::reg_access_t access,
  output logic                     csb_resp_valid,
  output csc_reg_pkg::csb_resp_t   csb_resp_pd
);

  import csc_reg_pkg::*;

  logic      req_pvld;
  csb_req_t  req_pd;
  csb_resp_t rresp;
  csb_resp_t wresp;

  assign csb_req_prdy = 1'b1; // never stalls

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: request capture
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb_req_pvld) begin
      req_pd <= csb_req_pd;
    end
  end

  // word address to byte offset
  assign access.offset  = {req_pd.addr[9:0], 2'b00};
  assign access.wr_data = req_pd.wdat;
  assign access.wr_en   = req_pvld & req_pd.write;
  assign access.rd_en   = req_pvld & ~req_pd.write;

  ////////////////////////////////////////////////////////////////////////////
  // stage 2: response
  assign rresp = '{is_write: 1'b0, error: 1'b0, rdat: rd_data};
  assign wresp = '{is_write: 1'b1, error: 1'b0, rdat: '0};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
      csb_resp_pd    <= '0;
    end else begin
      csb_resp_valid <= access.rd_en | (access.wr_en & req_pd.nposted);
      if (access.rd_en) begin
        csb_resp_pd <= rresp;
      end else if (access.wr_en && req_pd.nposted) begin
        csb_resp_pd <= wresp;
      end // posted write keeps the old payload
    end
  end

  a_req_pvld_known: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn) !$isunknown(csb_req_pvld)
  ) else $error("csb_req_pvld is X");

endmodule

// File: src/csc_single_group.sv
// shared pointer and status registers
`timescale 1ns/1ps

module csc_single_group (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  csc_reg_pkg::reg_access_t   access,
  input  logic                       consumer,
  input  csc_reg_pkg::group_status_e status_0,
  input  csc_reg_pkg::group_status_e status_1,
  output csc_reg_pkg::reg_data_t     rd_data,
  output logic                       producer
);

  import csc_reg_pkg::*;

  // producer pointer, software owned
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (access.wr_en && access.offset == REG_POINTER) begin
      producer <= access.wr_data[0];
    end
  end

  // read mux
  always_comb begin
    rd_data = '0;
    if (access.rd_en) begin
      case (access.offset)
        REG_STATUS:  rd_data = {14'b0, status_1, 14'b0, status_0};
        REG_POINTER: rd_data = {15'b0, consumer, 15'b0, producer};
        default:     rd_data = '0;
      endcase
    end
  end

endmodule

// File: src/csc_dual_group.sv
// duplicated layer config registers
`timescale 1ns/1ps

module csc_dual_group (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  csc_reg_pkg::reg_access_t access,
  input  logic                     op_en,
  output csc_reg_pkg::reg_data_t   rd_data,
  output csc_reg_pkg::conv_cfg_t   cfg,
  output logic                     op_en_trigger
);

  import csc_reg_pkg::*;

  reg_data_t wd;

  assign wd = access.wr_data;

  // op_en itself lives in the controller
  assign op_en_trigger = access.wr_en && (access.offset == REG_OP_ENABLE);

  ////////////////////////////////////////////////////////////////////////////
  // config fields
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (access.wr_en) begin
      case (access.offset)
        REG_MISC_CFG: begin
          cfg.conv_mode    <= wd[0];
          cfg.in_precision <= wd[9:8];
          cfg.batches      <= wd[20:16];
        end
        REG_DATAIN_SIZE_0: begin
          cfg.datain_width_ext  <= wd[12:0];
          cfg.datain_height_ext <= wd[28:16];
        end
        REG_DATAIN_SIZE_1: begin
          cfg.datain_channel_ext <= wd[12:0];
        end
        REG_PAD_VALUE: begin
          cfg.pad_value <= wd[15:0];
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback in register layout
  always_comb begin
    rd_data = '0;
    if (access.rd_en) begin
      case (access.offset)
        REG_OP_ENABLE:     rd_data = {31'b0, op_en};
        REG_MISC_CFG:      rd_data = {11'b0, cfg.batches, 6'b0, cfg.in_precision,
                                      7'b0, cfg.conv_mode};
        REG_DATAIN_SIZE_0: rd_data = {3'b0, cfg.datain_height_ext,
                                      3'b0, cfg.datain_width_ext};
        REG_DATAIN_SIZE_1: rd_data = {19'b0, cfg.datain_channel_ext};
        REG_PAD_VALUE:     rd_data = {16'b0, cfg.pad_value};
        default:           rd_data = '0;
      endcase
    end
  end

endmodule

// File: src/csc_pingpong_ctrl.sv
// ping-pong group controller
`timescale 1ns/1ps

module csc_pingpong_ctrl #(
  parameter int OP_EN_DELAY = 3,
  parameter int SLCG_WIDTH  = 4
) (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  csc_reg_pkg::reg_access_t   access,
  input  logic                       dp2reg_done,
  input  logic                       producer,
  input  csc_reg_pkg::reg_data_t     s_rd_data,
  input  csc_reg_pkg::reg_data_t     d0_rd_data,
  input  csc_reg_pkg::reg_data_t     d1_rd_data,
  input  logic                       d0_op_en_trigger,
  input  logic                       d1_op_en_trigger,
  input  csc_reg_pkg::conv_cfg_t     d0_cfg,
  input  csc_reg_pkg::conv_cfg_t     d1_cfg,
  output csc_reg_pkg::reg_access_t   s_access,
  output csc_reg_pkg::reg_access_t   d0_access,
  output csc_reg_pkg::reg_access_t   d1_access,
  output csc_reg_pkg::reg_data_t     rd_data,
  output logic                       consumer,
  output csc_reg_pkg::group_status_e status_0,
  output csc_reg_pkg::group_status_e status_1,
  output logic                       d0_op_en,
  output logic                       d1_op_en,
  output csc_reg_pkg::conv_cfg_t     reg2dp_cfg,
  output logic                       reg2dp_op_en,
  output logic [SLCG_WIDTH-1:0]      slcg_op_en
);

  import csc_reg_pkg::*;

  logic                   select_s;
  logic [1:0]             select_d;
  logic [1:0]             op_en;
  logic [1:0]             op_en_trigger;
  logic                   op_en_ori;                 // consumer group enable
  logic [OP_EN_DELAY-1:0] op_en_dly;
  logic [SLCG_WIDTH-1:0]  slcg_dly [OP_EN_DELAY];

  function automatic group_status_e group_status(input logic en, input logic is_consumer);
    if (!en) begin
      return GROUP_IDLE;
    end
    return is_consumer ? GROUP_RUNNING : GROUP_PENDING;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // access steering with writes gated while a group is armed
  assign select_s    = access.offset < DUAL_BASE;
  assign select_d[0] = !select_s && !producer;
  assign select_d[1] = !select_s && producer;

  assign s_access  = '{wr_en: access.wr_en & select_s, rd_en: access.rd_en & select_s,
                       offset: access.offset, wr_data: access.wr_data};
  assign d0_access = '{wr_en: access.wr_en & select_d[0] & ~op_en[0],
                       rd_en: access.rd_en & select_d[0],
                       offset: access.offset, wr_data: access.wr_data};
  assign d1_access = '{wr_en: access.wr_en & select_d[1] & ~op_en[1],
                       rd_en: access.rd_en & select_d[1],
                       offset: access.offset, wr_data: access.wr_data};

  assign rd_data = s_rd_data | d0_rd_data | d1_rd_data; // unselected groups read 0

  ////////////////////////////////////////////////////////////////////////////
  // consumer pointer and operation enables
  assign op_en_trigger = {d1_op_en_trigger, d0_op_en_trigger};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
      op_en    <= '0;
    end else begin
      if (dp2reg_done) begin
        consumer <= ~consumer;
      end
      for (int g = 0; g < 2; g++) begin
        if (!op_en[g] && op_en_trigger[g]) begin
          op_en[g] <= access.wr_data[0];
        end else if (dp2reg_done && consumer == g[0]) begin
          op_en[g] <= 1'b0; // layer finished
        end
      end
    end
  end

  assign d0_op_en   = op_en[0];
  assign d1_op_en   = op_en[1];
  assign status_0   = group_status(op_en[0], consumer == 1'b0);
  assign status_1   = group_status(op_en[1], consumer == 1'b1);
  assign reg2dp_cfg = consumer ? d1_cfg : d0_cfg;
  assign op_en_ori  = consumer ? op_en[1] : op_en[0];

  ////////////////////////////////////////////////////////////////////////////
  // delay lines
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_dly <= '0;
      for (int i = 0; i < OP_EN_DELAY; i++) begin
        slcg_dly[i] <= '0;
      end
    end else begin
      op_en_dly[0] <= dp2reg_done ? 1'b0 : op_en_ori;
      slcg_dly[0]  <= {SLCG_WIDTH{op_en_ori}}; // clock gating ignores done
      for (int i = 1; i < OP_EN_DELAY; i++) begin
        op_en_dly[i] <= dp2reg_done ? 1'b0 : op_en_dly[i-1];
        slcg_dly[i]  <= slcg_dly[i-1];
      end
    end
  end

  assign reg2dp_op_en = op_en_dly[OP_EN_DELAY-1];
  assign slcg_op_en   = slcg_dly[OP_EN_DELAY-1];

  // software must not touch an armed group
  a_no_write_armed: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(access.wr_en && |(select_d & op_en))
  ) else $error("config write to a group with op_en set");

  a_done_known: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn) !$isunknown(dp2reg_done)
  ) else $error("dp2reg_done is X");

endmodule

// File: src/csc_regfile.sv
// convolution sequencer register file
`timescale 1ns/1ps

module csc_regfile #(
  parameter int OP_EN_DELAY = 3,
  parameter int SLCG_WIDTH  = 4
) (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   csb_req_pvld,
  input  csc_reg_pkg::csb_req_t  csb_req_pd,
  input  logic                   dp2reg_done,
  output logic                   csb_req_prdy,
  output logic                   csb_resp_valid,
  output csc_reg_pkg::csb_resp_t csb_resp_pd,
  output csc_reg_pkg::conv_cfg_t reg2dp_cfg,
  output logic                   reg2dp_op_en,
  output logic [SLCG_WIDTH-1:0]  slcg_op_en
);

  import csc_reg_pkg::*;

  reg_access_t   access, s_access, d0_access, d1_access;
  reg_data_t     rd_data, s_rd_data, d0_rd_data, d1_rd_data;
  conv_cfg_t     d0_cfg, d1_cfg;
  group_status_e status_0, status_1;
  logic          producer, consumer;
  logic          d0_op_en, d1_op_en;
  logic          d0_op_en_trigger, d1_op_en_trigger;

  csc_csb_bridge u_csb_bridge (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_pvld, .csb_req_pd, .rd_data,
    .csb_req_prdy, .access, .csb_resp_valid, .csb_resp_pd
  );

  csc_single_group u_single_group (
    .nvdla_core_clk, .nvdla_core_rstn, .access (s_access), .consumer,
    .status_0, .status_1, .rd_data (s_rd_data), .producer
  );

  csc_dual_group u_dual_group_d0 (
    .nvdla_core_clk, .nvdla_core_rstn, .access (d0_access), .op_en (d0_op_en),
    .rd_data (d0_rd_data), .cfg (d0_cfg), .op_en_trigger (d0_op_en_trigger)
  );

  csc_dual_group u_dual_group_d1 (
    .nvdla_core_clk, .nvdla_core_rstn, .access (d1_access), .op_en (d1_op_en),
    .rd_data (d1_rd_data), .cfg (d1_cfg), .op_en_trigger (d1_op_en_trigger)
  );

  csc_pingpong_ctrl #(
    .OP_EN_DELAY (OP_EN_DELAY),
    .SLCG_WIDTH  (SLCG_WIDTH)
  ) u_pingpong_ctrl (
    .nvdla_core_clk, .nvdla_core_rstn, .access, .dp2reg_done, .producer,
    .s_rd_data, .d0_rd_data, .d1_rd_data, .d0_op_en_trigger, .d1_op_en_trigger,
    .d0_cfg, .d1_cfg, .s_access, .d0_access, .d1_access, .rd_data, .consumer,
    .status_0, .status_1, .d0_op_en, .d1_op_en, .reg2dp_cfg, .reg2dp_op_en, .slcg_op_en
  );

endmodule

// File: verification/csc_regfile_tb.sv
// register file testbench
`timescale 1ns/1ps

module csc_regfile_tb;

  import csc_reg_pkg::*;

  localparam int OP_EN_DELAY = 3;
  localparam int SLCG_WIDTH  = 4;
  localparam int N_TXN       = 2000;
  localparam int CYCLE_LIMIT = N_TXN * 4 + 100;

  logic                  nvdla_core_clk;
  logic                  nvdla_core_rstn;
  logic                  csb_req_pvld;
  csb_req_t              csb_req_pd;
  logic                  dp2reg_done;
  logic                  csb_req_prdy;
  logic                  csb_resp_valid;
  csb_resp_t             csb_resp_pd;
  conv_cfg_t             reg2dp_cfg;
  logic                  reg2dp_op_en;
  logic [SLCG_WIDTH-1:0] slcg_op_en;

  integer seed = 32'ha075d66f;
  int     cycles = 0;

  // reference model
  logic                   m_prod = 1'b0;
  logic                   m_cons = 1'b0;
  logic [1:0]             m_op_en = '0;
  conv_cfg_t              m_cfg [2] = '{default: '0};
  logic                   s1_valid = 1'b0;     // request registered in the bridge
  csb_req_t               s1_req = '0;
  logic                   exp_valid = 1'b0;
  csb_resp_t              exp_pd = '0;
  logic [OP_EN_DELAY-1:0] exp_op_line = '0;
  logic [OP_EN_DELAY-1:0] exp_slcg_line = '0;

  csc_regfile #(
    .OP_EN_DELAY (OP_EN_DELAY),
    .SLCG_WIDTH  (SLCG_WIDTH)
  ) uut (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_pvld, .csb_req_pd, .dp2reg_done,
    .csb_req_prdy, .csb_resp_valid, .csb_resp_pd, .reg2dp_cfg, .reg2dp_op_en, .slcg_op_en
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  always @(posedge nvdla_core_clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, run still going after %0d cycles", cycles);
      $display("Verification failed");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_resp(input string name, input csb_resp_t got, input csb_resp_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h (cycle %0d)", name, got, exp, cycles);
      $display("Verification failed");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_cfg(input string name, input conv_cfg_t got, input conv_cfg_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h (cycle %0d)", name, got, exp, cycles);
      $display("Verification failed");
      $fatal(1, "config mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h (cycle %0d)", name, got, exp, cycles);
      $display("Verification failed");
      $fatal(1, "enable mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model of the register rules
  function automatic group_status_e expected_status(input logic g);
    if (!m_op_en[g]) begin
      return GROUP_IDLE;
    end
    return (m_cons == g) ? GROUP_RUNNING : GROUP_PENDING;
  endfunction

  function automatic reg_data_t expected_read(input reg_offset_t off);
    reg_data_t w;
    conv_cfg_t c;
    w = '0;
    c = m_cfg[m_prod];                 // dual reads follow the producer
    case (off)
      REG_STATUS: begin
        w[1:0]   = expected_status(1'b0);
        w[17:16] = expected_status(1'b1);
      end
      REG_POINTER: begin
        w[0]  = m_prod;
        w[16] = m_cons;
      end
      REG_OP_ENABLE: w[0] = m_op_en[m_prod];
      REG_MISC_CFG: begin
        w[0]     = c.conv_mode;
        w[9:8]   = c.in_precision;
        w[20:16] = c.batches;
      end
      REG_DATAIN_SIZE_0: begin
        w[12:0]  = c.datain_width_ext;
        w[28:16] = c.datain_height_ext;
      end
      REG_DATAIN_SIZE_1: w[12:0] = c.datain_channel_ext;
      REG_PAD_VALUE:     w[15:0] = c.pad_value;
      default:           w = '0;
    endcase
    return w;
  endfunction

  // one clock edge with the inputs held over it
  task automatic model_edge();
    reg_offset_t off;
    logic [1:0]  op_en_old;
    conv_cfg_t   c;
    reg_data_t   wd;
    off       = {s1_req.addr[9:0], 2'b00};
    wd        = s1_req.wdat;
    op_en_old = m_op_en;
    exp_slcg_line = {exp_slcg_line[OP_EN_DELAY-2:0], m_op_en[m_cons]};
    if (dp2reg_done) begin
      exp_op_line = '0;
    end else begin
      exp_op_line = {exp_op_line[OP_EN_DELAY-2:0], m_op_en[m_cons]};
    end
    exp_valid = 1'b0;
    if (s1_valid && !s1_req.write) begin
      exp_valid = 1'b1;
      exp_pd    = '{is_write: 1'b0, error: 1'b0, rdat: expected_read(off)};
    end else if (s1_valid && s1_req.nposted) begin
      exp_valid = 1'b1;
      exp_pd    = '{is_write: 1'b1, error: 1'b0, rdat: '0};
    end
    if (s1_valid && s1_req.write && off >= DUAL_BASE && !op_en_old[m_prod]) begin
      c = m_cfg[m_prod];
      case (off)
        REG_MISC_CFG: begin
          c.conv_mode    = wd[0];
          c.in_precision = wd[9:8];
          c.batches      = wd[20:16];
        end
        REG_DATAIN_SIZE_0: begin
          c.datain_width_ext  = wd[12:0];
          c.datain_height_ext = wd[28:16];
        end
        REG_DATAIN_SIZE_1: c.datain_channel_ext = wd[12:0];
        REG_PAD_VALUE:     c.pad_value = wd[15:0];
        REG_OP_ENABLE:     m_op_en[m_prod] = wd[0];
        default: begin
        end
      endcase
      m_cfg[m_prod] = c;
    end
    if (dp2reg_done && op_en_old[m_cons]) begin
      m_op_en[m_cons] = 1'b0;          // finished layer
    end
    if (s1_valid && s1_req.write && off == REG_POINTER) begin
      m_prod = wd[0];
    end
    if (dp2reg_done) begin
      m_cons = ~m_cons;
    end
    s1_valid = csb_req_pvld;
    s1_req   = csb_req_pd;
  endtask

  task automatic check_outputs();
    check_bit("csb_req_prdy", csb_req_prdy, 1'b1);
    check_bit("csb_resp_valid", csb_resp_valid, exp_valid);
    check_resp("csb_resp_pd", csb_resp_pd, exp_pd);
    check_cfg("reg2dp_cfg", reg2dp_cfg, m_cfg[m_cons]);
    check_bit("reg2dp_op_en", reg2dp_op_en, exp_op_line[OP_EN_DELAY-1]);
    for (int i = 0; i < SLCG_WIDTH; i++) begin
      check_bit($sformatf("slcg_op_en[%0d]", i), slcg_op_en[i], exp_slcg_line[OP_EN_DELAY-1]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  // writes at DUAL_BASE and above only reach a group that stays disarmed
  function automatic logic dual_write_allowed();
    reg_offset_t pend;
    pend = {s1_req.addr[9:0], 2'b00};
    if (s1_valid && s1_req.write && (pend == REG_POINTER || pend == REG_OP_ENABLE)) begin
      return 1'b0;
    end
    return !m_op_en[m_prod];
  endfunction

  task automatic drive_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    reg_offset_t off;
    csb_req_t    req;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    req.level   = r0[31:30];
    req.wrbe    = r0[29:26];
    req.srcpriv = r0[25];
    req.nposted = r0[24];
    req.write   = 1'b0;
    req.wdat    = r1;
    case (r0[6:4])                     // read target
      3'd0:    off = REG_STATUS;
      3'd1:    off = REG_POINTER;
      3'd2:    off = REG_OP_ENABLE;
      3'd3:    off = REG_MISC_CFG;
      3'd4:    off = REG_DATAIN_SIZE_0;
      3'd5:    off = REG_DATAIN_SIZE_1;
      3'd6:    off = REG_PAD_VALUE;
      default: off = {2'b01, r2[9:2], 2'b00}; // unmapped
    endcase
    case (r0[3:0])
      4'd8:  off = REG_MISC_CFG;
      4'd9:  off = REG_DATAIN_SIZE_0;
      4'd10: off = REG_DATAIN_SIZE_1;
      4'd11: off = REG_PAD_VALUE;
      4'd12: off = REG_OP_ENABLE;
      4'd13: off = REG_POINTER;
      4'd14: off = REG_STATUS;         // read only word
      default: begin
      end
    endcase
    if (r0[3:0] inside {4'd13, 4'd14}) begin
      req.write = 1'b1;
    end else if (r0[3:0] inside {[4'd8:4'd12]}) begin
      req.write = dual_write_allowed(); // else read it back instead
    end
    if (off == REG_OP_ENABLE) begin
      req.wdat[0] = r1[0] | r1[1];     // mostly arm
    end
    req.addr     = {r2[21:10], off[11:2]};
    csb_req_pd   = req;
    csb_req_pvld = !(r0[3:0] inside {4'd0, 4'd1, 4'd2, 4'd15});
    dp2reg_done  = (r2[31:29] == 3'b000);
  endtask

  initial begin
    nvdla_core_rstn = 1'b0;
    csb_req_pvld    = 1'b0;
    csb_req_pd      = '0;
    dp2reg_done     = 1'b0;
    repeat (5) @(posedge nvdla_core_clk);
    #2 nvdla_core_rstn = 1'b1;
    for (int n = 0; n < N_TXN; n++) begin
      @(posedge nvdla_core_clk);
      #2;
      model_edge();
      check_outputs();
      drive_random();
    end
    repeat (OP_EN_DELAY + 3) begin     // drain the pipeline
      @(posedge nvdla_core_clk);
      #2;
      model_edge();
      check_outputs();
      csb_req_pvld = 1'b0;
      dp2reg_done  = 1'b0;
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: files.f
src/csc_reg_pkg.sv
src/csc_csb_bridge.sv
src/csc_single_group.sv
src/csc_dual_group.sv
src/csc_pingpong_ctrl.sv
src/csc_regfile.sv
verification/csc_regfile_tb.sv

// File: run.sh
#!/bin/sh
# build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timing --timescale 1ns/1ps -sv -f files.f \
  --top-module csc_regfile_tb --Mdir "$OBJ" -o csc_regfile_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/csc_regfile_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
